/* tb.f */
+incdir+src
src/rvwb_pkg.sv
src/result_format.sv
src/reg_file.sv
src/store_master.sv
src/wb_stage.sv
src/rvwb_top.sv
verif/wb_mem_slave.sv
verif/rvwb_tb.sv

/* Bender.yml */
package:
  name: rvwb

sources:
  - include_dirs:
      - src
    files:
      - src/rvwb_pkg.sv
      - src/result_format.sv
      - src/reg_file.sv
      - src/store_master.sv
      - src/wb_stage.sv
      - src/rvwb_top.sv
  - target: test
    files:
      - verif/wb_mem_slave.sv
      - verif/rvwb_tb.sv

/* verif/rvwb_tb.sv */
module rvwb_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int timeout_cycles = 40;

    logic                 clk;
    logic                 rst_n;
    logic                 in_valid;
    rvwb_pkg::wb_packet_t in_pkt;
    logic                 in_ready;
    logic                 halted;
    rvwb_pkg::xlen_t      retired_pc;
    rvwb_pkg::reg_addr_t  dbg_raddr;
    rvwb_pkg::xlen_t      dbg_rdata;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic                 wb_ack;
    rvwb_pkg::xlen_t      wb_adr;
    rvwb_pkg::xlen_t      wb_dat_w;
    rvwb_pkg::xlen_t      wb_dat_r;
    rvwb_pkg::byte_mask_t wb_sel;

    rvwb_top dut_i (.*);

    wb_mem_slave mem_i (
        .clk, .rst_n, .cyc (wb_cyc), .stb (wb_stb), .we (wb_we), .adr (wb_adr),
        .dat_w (wb_dat_w), .sel (wb_sel), .ack (wb_ack), .dat_r (wb_dat_r)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check(input rvwb_pkg::xlen_t got, input rvwb_pkg::xlen_t exp,
            input string msg);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s (got %h, expected %h)", $time, msg, got, exp);
            $display("Errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timed out waiting for %s at %0t ns", what, $time);
        $display("Errors found");
        $fatal(1, "simulation stopped after a timeout");
    endtask

    task automatic step();
        @(posedge clk);
        #2;   // drive just after the edge
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!in_ready) begin
            if (n == timeout_cycles) stop_on_timeout("in_ready");
            step();
            n++;
        end
    endtask

    task automatic send_pkt(input rvwb_pkg::wb_packet_t pkt);
        in_pkt   = pkt;
        in_valid = 1'b1;
        wait_ready();
        step();   // accept edge
        in_valid = 1'b0;
    endtask

    task automatic check_reg(input rvwb_pkg::reg_addr_t r, input rvwb_pkg::xlen_t exp,
            input string msg);
        dbg_raddr = r;
        #1;
        check(dbg_rdata, exp, msg);
    endtask

    function automatic rvwb_pkg::wb_packet_t alu_pkt(input rvwb_pkg::reg_addr_t rd,
            input rvwb_pkg::xlen_t val, input rvwb_pkg::ext_mode_e ext);
        rvwb_pkg::wb_packet_t p;
        p          = '0;
        p.exec_res = val;
        p.mem_res  = ~val;   // always differs from exec_res
        p.src      = rvwb_pkg::src_exec;
        p.ext      = ext;
        p.rd_wen   = 1'b1;
        p.rd       = rd;
        p.pc       = 64'h8000_0000 + 64'(rd) * 4;
        return p;
    endfunction

    function automatic rvwb_pkg::wb_packet_t store_pkt(input rvwb_pkg::reg_addr_t base,
            input rvwb_pkg::imm_t imm, input rvwb_pkg::byte_mask_t mask,
            input rvwb_pkg::xlen_t data);
        rvwb_pkg::wb_packet_t p;
        p          = '0;
        p.exec_res = data;
        p.is_store = 1'b1;
        p.base_reg = base;
        p.imm      = imm;
        p.wmask    = mask;
        p.rd       = 5'd8;   // rd_wen clear, x8 must stay put
        p.pc       = 64'h8000_1000;
        return p;
    endfunction

    function automatic rvwb_pkg::xlen_t snapshot(input rvwb_pkg::xlen_t adr);
        rvwb_pkg::xlen_t v;
        for (int i = 0; i < 8; i++) begin
            v[8*i +: 8] = mem_i.read_byte(adr + 64'(i));
        end
        return v;
    endfunction

    function automatic rvwb_pkg::xlen_t merge(input rvwb_pkg::xlen_t old,
            input rvwb_pkg::xlen_t data, input rvwb_pkg::byte_mask_t mask);
        rvwb_pkg::xlen_t m;
        m = old;
        for (int i = 0; i < 8; i++) begin
            if (mask[i]) m[8*i +: 8] = data[8*i +: 8];
        end
        return m;
    endfunction

    task automatic test_extension();
        send_pkt(alu_pkt(5'd1, 64'hfedc_ba98_8765_c321, rvwb_pkg::ext_none));
        send_pkt(alu_pkt(5'd2, 64'hfedc_ba98_8765_c321, rvwb_pkg::ext_word_signed));
        send_pkt(alu_pkt(5'd3, 64'hfedc_ba98_8765_c321, rvwb_pkg::ext_word_zero));
        send_pkt(alu_pkt(5'd4, 64'hfedc_ba98_8765_c321, rvwb_pkg::ext_half_signed));
        check_reg(5'd1, 64'hfedc_ba98_8765_c321, "ext_none keeps 64 bits");
        check_reg(5'd2, 64'hffff_ffff_8765_c321, "ext_word_signed");
        check_reg(5'd3, 64'h0000_0000_8765_c321, "ext_word_zero");
        check_reg(5'd4, 64'hffff_ffff_ffff_c321, "ext_half_signed");
        send_pkt(alu_pkt(5'd4, 64'h0123_4567_89ab_7def, rvwb_pkg::ext_half_signed));
        check_reg(5'd4, 64'h0000_0000_0000_7def, "ext_half_signed, positive half");
    endtask

    task automatic test_source();
        rvwb_pkg::wb_packet_t pkt;
        pkt     = alu_pkt(5'd5, 64'h1111_2222_3333_4444, rvwb_pkg::ext_none);
        pkt.src = rvwb_pkg::src_mem;
        send_pkt(pkt);
        check_reg(5'd5, 64'heeee_dddd_cccc_bbbb, "src_mem selects mem_res");
        send_pkt(alu_pkt(5'd6, 64'h1111_2222_3333_4444, rvwb_pkg::ext_none));
        check_reg(5'd6, 64'h1111_2222_3333_4444, "src_exec selects exec_res");
    endtask

    task automatic test_x0_and_wen();
        rvwb_pkg::wb_packet_t pkt;
        send_pkt(alu_pkt(5'd0, 64'hdead_beef_dead_beef, rvwb_pkg::ext_none));
        check_reg(5'd0, '0, "x0 reads zero after a write");
        pkt        = alu_pkt(5'd5, 64'h5555_5555_5555_5555, rvwb_pkg::ext_none);
        pkt.rd_wen = 1'b0;
        send_pkt(pkt);
        check_reg(5'd5, 64'heeee_dddd_cccc_bbbb, "rd_wen clear leaves x5");
    endtask

    task automatic test_store();
        rvwb_pkg::xlen_t old;
        rvwb_pkg::xlen_t above;
        send_pkt(alu_pkt(5'd7, 64'h0000_0000_0000_1000, rvwb_pkg::ext_none));
        old   = snapshot(64'h0ff8);
        above = snapshot(64'h1000);
        // base 0x1000 plus imm -8
        send_pkt(store_pkt(5'd7, 32'hffff_fff8, 8'b0011_0110, 64'h1122_3344_5566_7788));
        wait_ready();
        check(snapshot(64'h0ff8), merge(old, 64'h1122_3344_5566_7788, 8'b0011_0110),
            "masked store at base plus imm");
        check(snapshot(64'h1000), above, "bytes past the store untouched");
        check_reg(5'd7, 64'h0000_0000_0000_1000, "base register kept");
        check_reg(5'd8, '0, "store rd kept");
    endtask

    task automatic test_back_to_back();
        send_pkt(store_pkt(5'd0, 32'h0000_0300, 8'hff, 64'hcafe_f00d_0bad_c0de));
        send_pkt(alu_pkt(5'd9, 64'h0000_0000_0000_0099, rvwb_pkg::ext_none));
        check(snapshot(64'h0300), 64'hcafe_f00d_0bad_c0de, "store before the write");
        check_reg(5'd9, 64'h0000_0000_0000_0099, "write after the store");
    endtask

    task automatic test_ebreak();
        rvwb_pkg::wb_packet_t pkt;
        pkt           = '0;
        pkt.is_ebreak = 1'b1;
        pkt.pc        = 64'h8000_2040;
        send_pkt(pkt);
        check(halted, 1'b1, "halted after ebreak");
        check(retired_pc, 64'h8000_2040, "retired_pc of the ebreak");
        in_pkt   = alu_pkt(5'd10, 64'h0000_0000_0000_1234, rvwb_pkg::ext_none);
        in_valid = 1'b1;
        for (int n = 0; n < 10; n++) begin   // stage must refuse it throughout
            check(in_ready, 1'b0, "in_ready low while halted");
            check(halted, 1'b1, "halted stays high");
            step();
        end
        in_valid = 1'b0;
        check_reg(5'd10, '0, "x10 kept while halted");
        check(retired_pc, 64'h8000_2040, "retired_pc held while halted");
    endtask

    initial begin
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_pkt    = '0;
        dbg_raddr = '0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check(in_ready, 1'b1, "in_ready after reset");
        check(halted, 1'b0, "halted after reset");
        check(wb_cyc, 1'b0, "wb_cyc after reset");
        check(wb_stb, 1'b0, "wb_stb after reset");
        check(wb_we, 1'b0, "wb_we after reset");
        check(retired_pc, '0, "retired_pc after reset");
        test_extension();
        test_source();
        test_x0_and_wen();
        test_store();
        test_back_to_back();
        test_ebreak();
        $display("No errors");
        $finish;
    end

endmodule

/* verif/wb_mem_slave.sv */
module wb_mem_slave (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cyc,
    input  logic                 stb,
    input  logic                 we,
    input  rvwb_pkg::xlen_t      adr,
    input  rvwb_pkg::xlen_t      dat_w,
    input  rvwb_pkg::byte_mask_t sel,
    output logic                 ack,
    output rvwb_pkg::xlen_t      dat_r
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0]  mem [0:8191];   // 8 KiB, low 13 address bits
    logic [31:0] rng;
    logic [1:0]  wait_left;
    logic        busy;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [7:0] read_byte(input rvwb_pkg::xlen_t a);
        return mem[a[12:0]];
    endfunction

    initial begin
        for (int i = 0; i < 8192; i++) begin
            mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h3c;   // fill folded from the full index
        end
    end

    assign dat_r = '0;   // store-only port

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack       <= 1'b0;
            busy      <= 1'b0;
            wait_left <= '0;
            rng       <= 32'h1118_6435;
        end else begin
            ack <= 1'b0;
            if (cyc && stb && !ack) begin
                if (!busy) begin   // new cycle, draw 0..3 wait states
                    rng       <= xorshift32(rng);
                    wait_left <= rng[1:0];
                    busy      <= 1'b1;
                end else if (wait_left != '0) begin
                    wait_left <= wait_left - 2'd1;
                end else begin
                    ack  <= 1'b1;
                    busy <= 1'b0;
                    if (we) begin
                        for (int i = 0; i < 8; i++) begin
                            if (sel[i]) mem[adr[12:0] + 13'(i)] <= dat_w[8*i +: 8];
                        end
                    end
                end
            end
        end
    end

endmodule

/* src/rvwb_top.sv */
module rvwb_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  rvwb_pkg::wb_packet_t in_pkt,
    output logic                 in_ready,
    output logic                 halted,
    output rvwb_pkg::xlen_t      retired_pc,
    input  rvwb_pkg::reg_addr_t  dbg_raddr,
    output rvwb_pkg::xlen_t      dbg_rdata,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic                 wb_we,
    output rvwb_pkg::xlen_t      wb_adr,
    output rvwb_pkg::xlen_t      wb_dat_w,
    output rvwb_pkg::byte_mask_t wb_sel,
    input  logic                 wb_ack,
    input  rvwb_pkg::xlen_t      wb_dat_r    // no loads return through this port
);

    rvwb_pkg::xlen_t     mem_res;
    rvwb_pkg::xlen_t     exec_res;
    rvwb_pkg::res_src_e  src;
    rvwb_pkg::ext_mode_e ext;
    rvwb_pkg::xlen_t     res;
    logic                we;
    rvwb_pkg::reg_addr_t waddr;
    rvwb_pkg::xlen_t     wdata;
    rvwb_pkg::reg_addr_t raddr_a;
    rvwb_pkg::xlen_t     rdata_a;
    logic                req_valid;
    rvwb_pkg::wb_req_t   req;
    logic                req_done;

    wb_stage stage_i (
        .clk, .rst_n, .in_valid, .in_pkt, .in_ready, .halted, .retired_pc,
        .mem_res, .exec_res, .src, .ext, .res,
        .we, .waddr, .wdata, .raddr_a, .rdata_a,
        .req_valid, .req, .req_done
    );

    result_format format_i (
        .mem_res, .exec_res, .src, .ext, .res
    );

    reg_file rf_i (
        .clk, .rst_n, .we, .waddr, .wdata,
        .raddr_a, .rdata_a,
        .raddr_b (dbg_raddr),
        .rdata_b (dbg_rdata)
    );

    store_master store_i (
        .clk, .rst_n, .req_valid, .req, .req_done,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_sel, .wb_ack
    );

endmodule

/* src/wb_stage.sv */
module wb_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  rvwb_pkg::wb_packet_t in_pkt,
    output logic                 in_ready,
    output logic                 halted,
    output rvwb_pkg::xlen_t      retired_pc,
    output rvwb_pkg::xlen_t      mem_res,
    output rvwb_pkg::xlen_t      exec_res,
    output rvwb_pkg::res_src_e   src,
    output rvwb_pkg::ext_mode_e  ext,
    input  rvwb_pkg::xlen_t      res,
    output logic                 we,
    output rvwb_pkg::reg_addr_t  waddr,
    output rvwb_pkg::xlen_t      wdata,
    output rvwb_pkg::reg_addr_t  raddr_a,
    input  rvwb_pkg::xlen_t      rdata_a,
    output logic                 req_valid,
    output rvwb_pkg::wb_req_t    req,
    input  logic                 req_done
);

    typedef enum logic [1:0] {
        st_run,
        st_store_wait,
        st_halt
    } state_e;

    state_e state_q;
    logic   accept;

    assign in_ready = (state_q == st_run);
    assign halted   = (state_q == st_halt);
    assign accept   = in_valid && in_ready;

    // formatter works on the packet being accepted
    assign mem_res  = in_pkt.mem_res;
    assign exec_res = in_pkt.exec_res;
    assign src      = in_pkt.src;
    assign ext      = in_pkt.ext;

    assign we    = accept && in_pkt.rd_wen && !in_pkt.is_store && !in_pkt.is_ebreak;
    assign waddr = in_pkt.rd;
    assign wdata = res;

    // base register read before any write lands this cycle
    assign raddr_a   = in_pkt.base_reg;
    assign req_valid = accept && in_pkt.is_store;
    assign req.adr   = rdata_a + rvwb_pkg::xlen_t'(signed'(in_pkt.imm));
    assign req.dat   = res;
    assign req.sel   = in_pkt.wmask;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= st_run;
            retired_pc <= '0;
        end else begin
            if (accept) retired_pc <= in_pkt.pc;
            case (state_q)
                st_run: begin
                    if (accept && in_pkt.is_ebreak) begin
                        state_q <= st_halt;   // sticky until reset
                    end else if (accept && in_pkt.is_store) begin
                        state_q <= st_store_wait;
                    end
                end
                st_store_wait: begin
                    if (req_done) state_q <= st_run;
                end
                st_halt: state_q <= st_halt;
                default: state_q <= st_run;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (accept && in_pkt.is_store) |-> !in_pkt.rd_wen)
        else $error("wb_stage: store packet also requests a register write");

    // completion from the bus side only while a store is pending
    assert property (@(posedge clk) disable iff (!rst_n)
        req_done |-> (state_q == st_store_wait))
        else $error("wb_stage: req_done without an outstanding store");

endmodule

/* src/store_master.sv */
module store_master (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req_valid,
    input  rvwb_pkg::wb_req_t    req,
    output logic                 req_done,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic                 wb_we,
    output rvwb_pkg::xlen_t      wb_adr,
    output rvwb_pkg::xlen_t      wb_dat_w,
    output rvwb_pkg::byte_mask_t wb_sel,
    input  logic                 wb_ack
);

    typedef enum logic {
        st_idle,
        st_write
    } state_e;

    state_e            state_q;
    rvwb_pkg::wb_req_t req_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
        end else begin
            case (state_q)
                st_idle: begin
                    if (req_valid) state_q <= st_write;
                end
                st_write: begin
                    if (wb_ack) state_q <= st_idle;   // single write, drop next cycle
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // payload only, held for the whole cycle
    always_ff @(posedge clk) begin
        if ((state_q == st_idle) && req_valid) begin
            req_q <= req;
        end
    end

    assign wb_cyc   = (state_q == st_write);
    assign wb_stb   = (state_q == st_write);
    assign wb_we    = (state_q == st_write);   // stores only on this port
    assign wb_adr   = req_q.adr;
    assign wb_dat_w = req_q.dat;
    assign wb_sel   = req_q.sel;
    assign req_done = wb_cyc && wb_ack;

    // stage must wait for req_done before the next store
    assert property (@(posedge clk) disable iff (!rst_n)
        req_valid |-> (state_q == st_idle))
        else $error("store_master: request while a write is in flight");

    // classic handshake: address, data and select frozen until ack
    assert property (@(posedge clk) disable iff (!rst_n)
        (wb_cyc && !wb_ack) |=> (wb_cyc && $stable(wb_adr)
                                 && $stable(wb_dat_w) && $stable(wb_sel)))
        else $error("store_master: bus signals changed before ack");

endmodule

/* src/reg_file.sv */
`include "rvwb_settings.svh"

module reg_file (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                we,
    input  rvwb_pkg::reg_addr_t waddr,
    input  rvwb_pkg::xlen_t     wdata,
    input  rvwb_pkg::reg_addr_t raddr_a,
    output rvwb_pkg::xlen_t     rdata_a,
    input  rvwb_pkg::reg_addr_t raddr_b,
    output rvwb_pkg::xlen_t     rdata_b
);

    // x1..x31, x0 has no storage
    rvwb_pkg::xlen_t regs [1:`RVWB_NREGS-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `RVWB_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin   // x0 writes dropped
            regs[waddr] <= wdata;
        end
    end

    // port a feeds the store address, port b is the debug read
    always_comb begin
        if (raddr_a == '0) begin
            rdata_a = '0;
        end else begin
            rdata_a = regs[raddr_a];
        end
    end

    always_comb begin
        if (raddr_b == '0) begin
            rdata_b = '0;
        end else begin
            rdata_b = regs[raddr_b];
        end
    end

endmodule

/* src/result_format.sv */
`include "rvwb_settings.svh"

module result_format (
    input  rvwb_pkg::xlen_t     mem_res,
    input  rvwb_pkg::xlen_t     exec_res,
    input  rvwb_pkg::res_src_e  src,
    input  rvwb_pkg::ext_mode_e ext,
    output rvwb_pkg::xlen_t     res
);

    rvwb_pkg::xlen_t raw;

    assign raw = (src == rvwb_pkg::src_mem) ? mem_res : exec_res;

    always_comb begin
        case (ext)
            rvwb_pkg::ext_none: begin
                res = raw;
            end
            rvwb_pkg::ext_word_signed: begin
                res = {{(`RVWB_XLEN-32){raw[31]}}, raw[31:0]};
            end
            rvwb_pkg::ext_word_zero: begin
                res = {{(`RVWB_XLEN-32){1'b0}}, raw[31:0]};
            end
            rvwb_pkg::ext_half_signed: begin
                res = {{(`RVWB_XLEN-16){raw[15]}}, raw[15:0]};
            end
            default: begin
                // only reachable with an X or Z mode from upstream
                res = '0;
                assert final (1'b0)
                    else $error("result_format: unknown ext mode %b", ext);
            end
        endcase
    end

endmodule

/* src/rvwb_pkg.sv */
`include "rvwb_settings.svh"

package rvwb_pkg;

    typedef logic [`RVWB_XLEN-1:0]    xlen_t;
    typedef logic [`RVWB_RADDR_W-1:0] reg_addr_t;
    typedef logic [`RVWB_SEL_W-1:0]   byte_mask_t;
    typedef logic [31:0]              imm_t;       // store offset, sign-extended on use

    typedef enum logic {
        src_exec,                                  // alu / execute result
        src_mem                                    // memory stage result
    } res_src_e;

    typedef enum logic [1:0] {
        ext_none,                                  // full 64 bits
        ext_word_signed,                           // lw, addw and friends
        ext_word_zero,                             // lwu
        ext_half_signed                            // lh
    } ext_mode_e;

    typedef struct packed {
        xlen_t      exec_res;
        xlen_t      mem_res;
        res_src_e   src;
        ext_mode_e  ext;
        logic       rd_wen;
        reg_addr_t  rd;
        logic       is_store;
        reg_addr_t  base_reg;
        imm_t       imm;
        byte_mask_t wmask;
        logic       is_ebreak;
        xlen_t      pc;
    } wb_packet_t;

    typedef struct packed {
        xlen_t      adr;
        xlen_t      dat;
        byte_mask_t sel;
    } wb_req_t;

endpackage

/* src/rvwb_settings.svh */
`ifndef RVWB_SETTINGS_SVH
`define RVWB_SETTINGS_SVH

// RV64 integer data path width
`define RVWB_XLEN 64

// architectural register count, x0 included
`define RVWB_NREGS 32

// index width for the register file
`define RVWB_RADDR_W 5

// one enable per byte of a doubleword
`define RVWB_SEL_W 8

`endif
